// File: all.f
hw/spu32_pkg.sv
hw/spu32_cpu_alu.sv
hw/spu32_decoder.sv
hw/spu32_regfile.sv
hw/spu32_exec_ctrl.sv
hw/spu32_exec_top.sv
test/tb_exec.sv

// File: test/tb_exec.sv
`timescale 1ns/100ps

module tb_exec;

    localparam int pulse_limit = 40;
    // about twice the summed length of the tests
    localparam int cycle_limit = 20000;
    localparam int kind_wb  = 1;
    localparam int kind_br  = 2;
    localparam int kind_ill = 3;

    logic        I_clk = 1'b0;
    logic        I_reset;
    logic [31:0] instr;
    logic        instr_valid;
    logic        instr_ready;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        br_valid;
    logic        br_taken;
    logic        illegal_instr;

    // expected architectural register state
    logic [31:0] shadow [32];
    logic [31:0] lfsr_state = 32'd11;
    int          value_errs = 0;
    int          proto_errs = 0;
    int          cycles = 0;

    spu32_exec_top u_dut (
        .I_clk         (I_clk),
        .I_reset       (I_reset),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .instr_ready   (instr_ready),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .br_valid      (br_valid),
        .br_taken      (br_taken),
        .illegal_instr (illegal_instr)
    );

    always #2 I_clk = ~I_clk;

    always @(posedge I_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles without finishing", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] next_random(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm12, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm12, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {7'b0, rs2, rs1, f3, 5'b0, 7'b1100011};
    endfunction

    // rv32i result for each funct3 with alt selecting sub and sra
    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic model_branch(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        value_errs++;
    endtask

    task automatic send_instr(input logic [31:0] word, output bit sent);
        int n;
        n = 0;
        sent = 1'b0;
        instr       <= word;
        instr_valid <= 1'b1;
        while (!sent && n < pulse_limit) begin
            @(posedge I_clk);
            n++;
            sent = instr_ready;
        end
        instr_valid <= 1'b0;
        assert (sent) else begin
            $display("instruction %h was never accepted", word);
            proto_errs++;
        end
    endtask

    task automatic wait_pulse(output int kind, output logic [4:0] rd, output logic [31:0] data,
                              output logic taken);
        int n;
        n = 0;
        kind = 0;
        while (kind == 0 && n < pulse_limit) begin
            @(posedge I_clk);
            n++;
            assert ($countones({wb_valid, br_valid, illegal_instr}) <= 1) else begin
                $display("more than one result pulse in the same cycle");
                proto_errs++;
            end
            if (wb_valid) begin
                kind = kind_wb;
            end else if (br_valid) begin
                kind = kind_br;
            end else if (illegal_instr) begin
                kind = kind_ill;
            end
        end
        rd    = wb_rd;
        data  = wb_data;
        taken = br_taken;
        assert (kind != 0) else begin
            $display("no result pulse within %0d cycles", pulse_limit);
            proto_errs++;
        end
    endtask

    task automatic issue_write(input string name, input logic [31:0] word,
                               input logic [4:0] exp_rd, input logic [31:0] exp_data);
        bit          sent;
        int          kind;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        taken;
        send_instr(word, sent);
        if (sent) begin
            wait_pulse(kind, rd, data, taken);
            assert (kind == kind_wb) else begin
                $display("%s gave pulse kind %0d instead of a write-back", name, kind);
                proto_errs++;
            end
            assert (rd === exp_rd) else report_value({name, " rd"}, exp_rd, rd);
            assert (data === exp_data) else report_value(name, exp_data, data);
        end
        if (exp_rd != 5'd0) begin
            shadow[exp_rd] = exp_data;
        end
    endtask

    task automatic issue_op(input string name, input logic [6:0] f7, input logic [4:0] rs2,
                            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        issue_write(name, r_type(f7, rs2, rs1, f3, rd), rd,
                    model_alu(f3, f7[5], shadow[rs1], shadow[rs2]));
    endtask

    task automatic issue_opimm(input string name, input logic [11:0] imm12,
                               input logic [4:0] rs1, input logic [2:0] f3,
                               input logic [4:0] rd);
        logic alt;
        alt = (f3 == 3'b101) && imm12[10];
        issue_write(name, i_type(imm12, rs1, f3, rd), rd,
                    model_alu(f3, alt, shadow[rs1], {{20{imm12[11]}}, imm12}));
    endtask

    // lui then addi with the upper part rounded for the sign of the low part
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] hi;
        hi = value[31:12] + value[11];
        issue_write("lui", {hi, rd, 7'b0110111}, rd, {hi, 12'b0});
        issue_opimm("addi after lui", value[11:0], rd, 3'b000, rd);
    endtask

    task automatic issue_branch(input string name, input logic [2:0] f3,
                                input logic [4:0] rs1, input logic [4:0] rs2);
        bit          sent;
        int          kind;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        taken;
        logic        exp;
        exp = model_branch(f3, shadow[rs1], shadow[rs2]);
        send_instr(b_type(f3, rs1, rs2), sent);
        if (sent) begin
            wait_pulse(kind, rd, data, taken);
            assert (kind == kind_br) else begin
                $display("%s gave pulse kind %0d instead of a branch report", name, kind);
                proto_errs++;
            end
            assert (taken === exp) else report_value(name, exp, taken);
        end
    endtask

    task automatic issue_illegal(input string name, input logic [31:0] word);
        bit          sent;
        int          kind;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        taken;
        send_instr(word, sent);
        if (sent) begin
            wait_pulse(kind, rd, data, taken);
            assert (kind == kind_ill) else begin
                $display("%s gave pulse kind %0d instead of an illegal report", name, kind);
                proto_errs++;
            end
        end
    endtask

    task automatic reset_state_test();
        for (int i = 0; i < 8; i++) begin
            @(posedge I_clk);
            // outputs are defined from the first reset edge on
            if (i > 0) begin
                assert (instr_ready === 1'b0 && wb_valid === 1'b0 && br_valid === 1'b0
                        && illegal_instr === 1'b0) else begin
                    $display("an output was not low during reset");
                    proto_errs++;
                end
            end
        end
        I_reset <= 1'b0;
        @(posedge I_clk);
        assert (instr_ready === 1'b0) else begin
            $display("instr_ready was high before reset was released");
            proto_errs++;
        end
        @(posedge I_clk);
        assert (instr_ready === 1'b1) else begin
            $display("instr_ready did not rise after reset");
            proto_errs++;
        end
    endtask

    task automatic arith_logic_test();
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        for (int r = 1; r <= 6; r++) begin
            load_reg(5'(r), next_random(32));
        end
        load_reg(5'd7, 32'h7fffffff);
        load_reg(5'd8, 32'h80000000);
        load_reg(5'd9, 32'hffffffff);
        load_reg(5'd10, 32'h00000001);
        // across the sign boundary
        issue_op("slt max,min", 7'b0, 5'd8, 5'd7, 3'b010, 5'd11);
        issue_op("sltu max,min", 7'b0, 5'd8, 5'd7, 3'b011, 5'd11);
        issue_op("slt -1,1", 7'b0, 5'd10, 5'd9, 3'b010, 5'd11);
        issue_op("sltu -1,1", 7'b0, 5'd10, 5'd9, 3'b011, 5'd11);
        issue_opimm("slti min,-1", 12'hfff, 5'd8, 3'b010, 5'd11);
        issue_opimm("sltiu 1,-1", 12'hfff, 5'd10, 3'b011, 5'd11);
        issue_op("sub min,1", 7'b0100000, 5'd10, 5'd8, 3'b000, 5'd11);
        issue_op("add max,1", 7'b0, 5'd10, 5'd7, 3'b000, 5'd11);
        for (int i = 0; i < 200; i++) begin
            f3 = 3'(next_random(3));
            if (f3 == 3'b001 || f3 == 3'b101) begin
                f3 = 3'b000;
            end
            f7  = (f3 == 3'b000 && next_random(1) == 1) ? 7'b0100000 : 7'b0;
            rs1 = 5'(1 + next_random(4) % 10);
            rs2 = 5'(1 + next_random(4) % 10);
            rd  = 5'(11 + next_random(3));
            issue_op($sformatf("op f3=%0d alt=%0d", f3, f7[5]), f7, rs2, rs1, f3, rd);
            f3 = 3'(next_random(3));
            if (f3 == 3'b001 || f3 == 3'b101) begin
                f3 = 3'b100;
            end
            issue_opimm($sformatf("op-imm f3=%0d", f3), 12'(next_random(12)), rs1, f3, rd);
        end
    endtask

    // a held instruction must wait for the shift's write-back
    task automatic held_during_shift();
        bit          sent;
        bit          seen_wb;
        bit          moved;
        int          n;
        int          kind;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        taken;
        logic [31:0] exp_shift;
        exp_shift = model_alu(3'b101, 1'b1, shadow[8], 32'd31);
        seen_wb   = 1'b0;
        moved     = 1'b0;
        n         = 0;
        send_instr(i_type({7'b0100000, 5'd31}, 5'd8, 3'b101, 5'd15), sent);
        instr       <= r_type(7'b0, 5'd10, 5'd15, 3'b000, 5'd16);
        instr_valid <= 1'b1;
        while (!moved && n < 2 * pulse_limit) begin
            @(posedge I_clk);
            n++;
            if (wb_valid) begin
                seen_wb = 1'b1;
                assert (wb_data === exp_shift) else report_value("held srai", exp_shift, wb_data);
            end
            if (instr_ready) begin
                moved = 1'b1;
                assert (seen_wb) else begin
                    $display("held instruction accepted before the shift finished");
                    proto_errs++;
                end
            end
        end
        instr_valid <= 1'b0;
        shadow[15] = exp_shift;
        assert (moved) else begin
            $display("held instruction was never accepted");
            proto_errs++;
        end
        if (moved) begin
            wait_pulse(kind, rd, data, taken);
            assert (kind == kind_wb) else begin
                $display("held add gave pulse kind %0d instead of a write-back", kind);
                proto_errs++;
            end
            assert (rd === 5'd16) else report_value("held add rd", 32'd16, rd);
            assert (data === shadow[15] + shadow[10])
                else report_value("held add", shadow[15] + shadow[10], data);
            shadow[16] = shadow[15] + shadow[10];
        end
    endtask

    task automatic shift_test();
        logic [4:0]  sh;
        logic [31:0] rnd;
        for (int i = 0; i < 40; i++) begin
            sh  = (i == 0) ? 5'd0 : (i == 1) ? 5'd1 : (i == 2) ? 5'd31 : 5'(next_random(5));
            rnd = next_random(27);
            // only the low five bits of rs2 count
            load_reg(5'd12, {rnd[26:0], sh});
            issue_op($sformatf("sll by %0d", sh), 7'b0, 5'd12, 5'd1, 3'b001, 5'd13);
            issue_op($sformatf("srl by %0d", sh), 7'b0, 5'd12, 5'd8, 3'b101, 5'd13);
            issue_op($sformatf("sra by %0d", sh), 7'b0100000, 5'd12, 5'd8, 3'b101, 5'd13);
            issue_op($sformatf("sra x2 by %0d", sh), 7'b0100000, 5'd12, 5'd2, 3'b101, 5'd13);
            issue_opimm($sformatf("slli by %0d", sh), {7'b0, sh}, 5'd1, 3'b001, 5'd14);
            issue_opimm($sformatf("srli by %0d", sh), {7'b0, sh}, 5'd9, 3'b101, 5'd14);
            issue_opimm($sformatf("srai by %0d", sh), {7'b0100000, sh}, 5'd8, 3'b101, 5'd14);
        end
        held_during_shift();
    endtask

    task automatic branch_test();
        logic [2:0] conds [6];
        logic [4:0] lhs [6];
        logic [4:0] rhs [6];
        conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        // equal, less, greater and sign-differing pairs
        lhs = '{5'd1, 5'd2, 5'd10, 5'd7, 5'd8, 5'd10};
        rhs = '{5'd1, 5'd19, 5'd7, 5'd10, 5'd10, 5'd9};
        issue_opimm("copy x2", 12'h000, 5'd2, 3'b000, 5'd19);
        for (int p = 0; p < 6; p++) begin
            for (int c = 0; c < 6; c++) begin
                issue_branch($sformatf("branch f3=%0d x%0d,x%0d", conds[c], lhs[p], rhs[p]),
                             conds[c], lhs[p], rhs[p]);
            end
        end
    endtask

    task automatic x0_illegal_test();
        issue_opimm("addi x0", 12'h123, 5'd1, 3'b000, 5'd0);
        issue_op("add x0,x0", 7'b0, 5'd0, 5'd0, 3'b000, 5'd20);
        issue_op("or x0,x2", 7'b0, 5'd2, 5'd0, 3'b110, 5'd20);
        issue_op("sub x2,x0", 7'b0100000, 5'd0, 5'd2, 3'b000, 5'd20);
        issue_illegal("unknown opcode", {12'h5a5, 5'd1, 3'b000, 5'd5, 7'b0001011});
        issue_opimm("x5 after unknown opcode", 12'h000, 5'd5, 3'b000, 5'd21);
        issue_illegal("bad funct7 on op", r_type(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd6));
        issue_opimm("x6 after bad funct7", 12'h000, 5'd6, 3'b000, 5'd21);
        issue_illegal("bad funct7 on slli", i_type({7'b0100000, 5'd3}, 5'd1, 3'b001, 5'd4));
        issue_opimm("x4 after bad slli", 12'h000, 5'd4, 3'b000, 5'd21);
    endtask

    initial begin
        I_reset     = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        reset_state_test();
        arith_logic_test();
        shift_test();
        branch_test();
        x0_illegal_test();
        $display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: hw/spu32_exec_top.sv
`timescale 1ns/100ps

module spu32_exec_top #(
    parameter bit single_cycle_shift = 1'b0
) (
    input  logic                        I_clk,
    input  logic                        I_reset,
    input  logic [31:0]                 instr,
    input  logic                        instr_valid,
    output logic                        instr_ready,
    output logic                        wb_valid,
    output logic [4:0]                  wb_rd,
    output logic [spu32_pkg::xlen-1:0]  wb_data,
    output logic                        br_valid,
    output logic                        br_taken,
    output logic                        illegal_instr
);
    import spu32_pkg::*;

    logic [31:0]     instr_q;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    alu_op_t         aluop;
    logic            use_imm;
    logic            zero_a;
    logic            is_branch;
    br_cond_t        br_cond;
    logic            writes_rd;
    logic            illegal;
    logic [xlen-1:0] rdata_a;
    logic [xlen-1:0] rdata_b;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [xlen-1:0] rf_wdata;
    logic            alu_en;
    logic [xlen-1:0] alu_s1;
    logic [xlen-1:0] alu_s2;
    logic            alu_busy;
    logic [xlen-1:0] alu_data;
    logic            alu_lt;
    logic            alu_ltu;
    logic            alu_eq;

    spu32_decoder u_decoder (
        .instr     (instr_q),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .aluop     (aluop),
        .use_imm   (use_imm),
        .zero_a    (zero_a),
        .is_branch (is_branch),
        .br_cond   (br_cond),
        .writes_rd (writes_rd),
        .illegal   (illegal)
    );

    spu32_regfile u_regfile (
        .I_clk   (I_clk),
        .I_reset (I_reset),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .we      (rf_we),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    spu32_exec_ctrl #(
        .single_cycle_shift (single_cycle_shift)
    ) u_ctrl (
        .I_clk         (I_clk),
        .I_reset       (I_reset),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .rd            (rd),
        .imm           (imm),
        .use_imm       (use_imm),
        .zero_a        (zero_a),
        .is_branch     (is_branch),
        .br_cond       (br_cond),
        .writes_rd     (writes_rd),
        .illegal       (illegal),
        .rdata_a       (rdata_a),
        .rdata_b       (rdata_b),
        .alu_busy      (alu_busy),
        .alu_data      (alu_data),
        .alu_lt        (alu_lt),
        .alu_ltu       (alu_ltu),
        .alu_eq        (alu_eq),
        .instr_ready   (instr_ready),
        .instr_q       (instr_q),
        .alu_en        (alu_en),
        .alu_s1        (alu_s1),
        .alu_s2        (alu_s2),
        .rf_we         (rf_we),
        .rf_waddr      (rf_waddr),
        .rf_wdata      (rf_wdata),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .br_valid      (br_valid),
        .br_taken      (br_taken),
        .illegal_instr (illegal_instr)
    );

    spu32_cpu_alu #(
        .single_cycle_shift (single_cycle_shift)
    ) u_alu (
        .I_clk   (I_clk),
        .I_reset (I_reset),
        .en      (alu_en),
        .data_s1 (alu_s1),
        .data_s2 (alu_s2),
        .aluop   (aluop),
        .busy    (alu_busy),
        .data    (alu_data),
        .lt      (alu_lt),
        .ltu     (alu_ltu),
        .eq      (alu_eq)
    );

endmodule

// File: hw/spu32_exec_ctrl.sv
`timescale 1ns/100ps

module spu32_exec_ctrl #(
    parameter bit single_cycle_shift = 1'b0
) (
    input  logic                        I_clk,
    input  logic                        I_reset,
    input  logic [31:0]                 instr,
    input  logic                        instr_valid,
    input  logic [4:0]                  rd,
    input  logic [spu32_pkg::xlen-1:0]  imm,
    input  logic                        use_imm,
    input  logic                        zero_a,
    input  logic                        is_branch,
    input  spu32_pkg::br_cond_t         br_cond,
    input  logic                        writes_rd,
    input  logic                        illegal,
    input  logic [spu32_pkg::xlen-1:0]  rdata_a,
    input  logic [spu32_pkg::xlen-1:0]  rdata_b,
    input  logic                        alu_busy,
    input  logic [spu32_pkg::xlen-1:0]  alu_data,
    input  logic                        alu_lt,
    input  logic                        alu_ltu,
    input  logic                        alu_eq,
    output logic                        instr_ready,
    output logic [31:0]                 instr_q,
    output logic                        alu_en,
    output logic [spu32_pkg::xlen-1:0]  alu_s1,
    output logic [spu32_pkg::xlen-1:0]  alu_s2,
    output logic                        rf_we,
    output logic [4:0]                  rf_waddr,
    output logic [spu32_pkg::xlen-1:0]  rf_wdata,
    output logic                        wb_valid,
    output logic [4:0]                  wb_rd,
    output logic [spu32_pkg::xlen-1:0]  wb_data,
    output logic                        br_valid,
    output logic                        br_taken,
    output logic                        illegal_instr
);
    import spu32_pkg::*;

    typedef enum logic [1:0] {st_idle, st_exec, st_wait, st_done} state_t;

    state_t state;
    state_t state_n;
    logic   taken_c;
    logic   finish;

    // result is ready once the ALU has run and no shift is pending
    assign finish = (state == st_wait) && !alu_busy;

    always_comb begin
        case (state)
            st_idle: state_n = (instr_valid && instr_ready) ? st_exec : st_idle;
            st_exec: state_n = st_wait;
            st_wait: state_n = alu_busy ? st_wait : st_done;
            default: state_n = st_idle;
        endcase
    end

    // keep enable up through a multi-cycle shift
    assign alu_en = (state == st_exec) || (state == st_wait && alu_busy);
    assign alu_s1 = zero_a ? '0 : rdata_a;
    assign alu_s2 = use_imm ? imm : rdata_b;

    always_comb begin
        case (br_cond)
            br_beq:  taken_c = alu_eq;
            br_bne:  taken_c = !alu_eq;
            br_blt:  taken_c = alu_lt;
            br_bge:  taken_c = !alu_lt;
            br_bltu: taken_c = alu_ltu;
            br_bgeu: taken_c = !alu_ltu;
            default: taken_c = 1'b0;
        endcase
    end

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            state         <= st_idle;
            instr_ready   <= 1'b0;
            wb_valid      <= 1'b0;
            br_valid      <= 1'b0;
            illegal_instr <= 1'b0;
        end else begin
            state         <= state_n;
            instr_ready   <= (state_n == st_idle);
            wb_valid      <= finish && writes_rd;
            br_valid      <= finish && is_branch;
            illegal_instr <= finish && illegal;
        end
    end

    always_ff @(posedge I_clk) begin
        if (state == st_idle && instr_valid && instr_ready) begin
            instr_q <= instr;
        end
        if (finish) begin
            wb_rd    <= rd;
            wb_data  <= alu_data;
            br_taken <= taken_c;
        end
    end

    // register write lands on the same edge that samples the pulse
    assign rf_we    = wb_valid;
    assign rf_waddr = wb_rd;
    assign rf_wdata = wb_data;

    a_ready_not_during_busy: assert property (
        @(posedge I_clk) disable iff (I_reset)
        !(alu_busy && (instr_ready || single_cycle_shift))
    );

endmodule

// File: hw/spu32_regfile.sv
`timescale 1ns/100ps

module spu32_regfile (
    input  logic                        I_clk,
    input  logic                        I_reset,
    input  logic [4:0]                  raddr_a,
    input  logic [4:0]                  raddr_b,
    input  logic [4:0]                  waddr,
    input  logic [spu32_pkg::xlen-1:0]  wdata,
    input  logic                        we,
    output logic [spu32_pkg::xlen-1:0]  rdata_a,
    output logic [spu32_pkg::xlen-1:0]  rdata_b
);
    import spu32_pkg::*;

    logic [xlen-1:0] regs [32];

    // x0 is cleared by reset and never written
    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    a_x0_reads_zero: assert property (
        @(posedge I_clk) disable iff (I_reset)
        ((raddr_a == 5'd0) |-> (rdata_a == '0)) and ((raddr_b == 5'd0) |-> (rdata_b == '0))
    );

endmodule

// File: hw/spu32_decoder.sv
`timescale 1ns/100ps

module spu32_decoder (
    input  logic [31:0]                 instr,
    output logic [4:0]                  rs1,
    output logic [4:0]                  rs2,
    output logic [4:0]                  rd,
    output logic [spu32_pkg::xlen-1:0]  imm,
    output spu32_pkg::alu_op_t          aluop,
    output logic                        use_imm,
    output logic                        zero_a,
    output logic                        is_branch,
    output spu32_pkg::br_cond_t         br_cond,
    output logic                        writes_rd,
    output logic                        illegal
);
    import spu32_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        // I-type immediate unless LUI overrides it
        imm       = {{(xlen-12){instr[31]}}, instr[31:20]};
        aluop     = alu_add;
        use_imm   = 1'b0;
        zero_a    = 1'b0;
        is_branch = 1'b0;
        br_cond   = br_cond_t'(funct3);
        writes_rd = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            opc_op: begin
                writes_rd = 1'b1;
                if (funct7 == 7'b0000000) begin
                    aluop = alu_op_t'({1'b0, funct3});
                end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
                    aluop = alu_op_t'({1'b1, funct3});
                end else begin
                    illegal = 1'b1;
                end
            end
            opc_op_imm: begin
                writes_rd = 1'b1;
                use_imm   = 1'b1;
                case (funct3)
                    3'b001: begin
                        aluop   = alu_sll;
                        illegal = (funct7 != 7'b0000000);
                    end
                    3'b101: begin
                        if (funct7 == 7'b0000000) begin
                            aluop = alu_srl;
                        end else if (funct7 == 7'b0100000) begin
                            aluop = alu_sra;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                    default: aluop = alu_op_t'({1'b0, funct3});
                endcase
            end
            opc_lui: begin
                imm       = {instr[31:12], 12'b0};
                zero_a    = 1'b1;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            opc_branch: begin
                // compare through the subtractor flags
                aluop = alu_sub;
                if (funct3[2:1] == 2'b01) begin
                    illegal = 1'b1;
                end else begin
                    is_branch = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
        // nothing is committed for a rejected encoding
        if (illegal) begin
            writes_rd = 1'b0;
        end
    end

endmodule

// File: hw/spu32_cpu_alu.sv
`timescale 1ns/100ps

module spu32_cpu_alu #(
    parameter bit single_cycle_shift = 1'b0
) (
    input  logic                         I_clk,
    input  logic                         I_reset,
    input  logic                         en,
    input  logic [spu32_pkg::xlen-1:0]   data_s1,
    input  logic [spu32_pkg::xlen-1:0]   data_s2,
    input  spu32_pkg::alu_op_t           aluop,
    output logic                         busy,
    output logic [spu32_pkg::xlen-1:0]   data,
    output logic                         lt,
    output logic                         ltu,
    output logic                         eq
);
    import spu32_pkg::*;

    logic [xlen-1:0] sum;
    logic [xlen-1:0] res_or;
    logic [xlen-1:0] res_xor;
    logic [xlen-1:0] res_and;
    // extra top bit catches the borrow
    logic [xlen:0]   diff;
    logic            lt_c;
    logic            ltu_c;
    logic            eq_c;
    logic [xlen-1:0] sll_c;
    logic            sign_fill;
    logic [xlen:0]   sr_ext;
    logic [4:0]      shift_cnt;

    assign sum     = data_s1 + data_s2;
    assign diff    = {1'b0, data_s1} - {1'b0, data_s2};
    assign res_or  = data_s1 | data_s2;
    assign res_xor = data_s1 ^ data_s2;
    assign res_and = data_s1 & data_s2;

    // borrow gives unsigned order, differing signs flip it for signed
    assign ltu_c = diff[xlen];
    assign lt_c  = diff[xlen] ^ res_xor[xlen-1];
    assign eq_c  = (diff[xlen-1:0] == '0);

    // barrel shifters, only selected in single cycle mode
    assign sll_c     = data_s1 << data_s2[4:0];
    assign sign_fill = (aluop == alu_sra) & data_s1[xlen-1];
    assign sr_ext    = $unsigned($signed({sign_fill, data_s1}) >>> data_s2[4:0]);

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            busy <= 1'b0;
        end else if (en) begin
            lt  <= lt_c;
            ltu <= ltu_c;
            eq  <= eq_c;
            case (aluop)
                alu_sub:  data <= diff[xlen-1:0];
                alu_and:  data <= res_and;
                alu_or:   data <= res_or;
                alu_xor:  data <= res_xor;
                alu_slt:  data <= {{(xlen-1){1'b0}}, lt_c};
                alu_sltu: data <= {{(xlen-1){1'b0}}, ltu_c};
                alu_sll, alu_srl, alu_sra: begin
                    if (single_cycle_shift) begin
                        data <= (aluop == alu_sll) ? sll_c : sr_ext[xlen-1:0];
                    end else if (!busy) begin
                        // load operand and count, then one bit per cycle
                        busy      <= 1'b1;
                        data      <= data_s1;
                        shift_cnt <= data_s2[4:0];
                    end else if (shift_cnt != 5'd0) begin
                        case (aluop)
                            alu_sll: data <= {data[xlen-2:0], 1'b0};
                            alu_srl: data <= {1'b0, data[xlen-1:1]};
                            default: data <= {data[xlen-1], data[xlen-1:1]};
                        endcase
                        shift_cnt <= shift_cnt - 5'd1;
                    end else begin
                        busy <= 1'b0;
                    end
                end
                default: data <= sum;
            endcase
        end
    end

    a_busy_clear_after_reset: assert property (@(posedge I_clk) I_reset |=> !busy);

    // operation must be held by the sequencer for the whole shift
    a_op_stable_while_busy: assert property (
        @(posedge I_clk) disable iff (I_reset) busy |-> $stable(aluop)
    );

endmodule

// File: hw/spu32_pkg.sv
package spu32_pkg;

    // data word width for operands, results and immediates
    parameter int xlen = 32;

    // low three bits follow funct3, bit 3 marks the alternate form
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    // encoded as the branch funct3 field
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } br_cond_t;

    // major opcodes handled by the decoder
    parameter logic [6:0] opc_op     = 7'b0110011;
    parameter logic [6:0] opc_op_imm = 7'b0010011;
    parameter logic [6:0] opc_lui    = 7'b0110111;
    parameter logic [6:0] opc_branch = 7'b1100011;

endpackage
